/* design/dram_geom_pkg.sv */
`default_nettype none

// geometry of one chip: 2 bank groups x 4 banks, 256 rows, 16 columns
package dram_geom_pkg;

    localparam int BG_BITS   = 1;  // bank group index
    localparam int BA_BITS   = 2;  // bank within group
    localparam int BANK_BITS = BG_BITS + BA_BITS;
    localparam int NUM_BANKS = 1 << BANK_BITS;

    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;

    // address, msb first: row, bank group, bank, column
    localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;

    localparam int DATA_BITS = 32;

    // flat bank index is {bank group, bank}
    typedef logic [BANK_BITS-1:0] bank_t;

    typedef logic [ROW_BITS-1:0]  row_t;

    typedef logic [COL_BITS-1:0]  col_t;

    typedef logic [ADDR_BITS-1:0] addr_t;

    typedef logic [DATA_BITS-1:0] data_t;

endpackage

`default_nettype wire

/* design/dram_cmd_pkg.sv */
`default_nettype none

// command encoding on cmd_out and the request word held in the bank queues
package dram_cmd_pkg;

    typedef enum logic [1:0] {
        READ      = 2'd0,
        WRITE     = 2'd1,
        ACTIVATE  = 2'd2,
        PRECHARGE = 2'd3
    } cmd_t;

    // the bank is implied by the queue holding the request
    typedef struct packed {
        dram_geom_pkg::row_t  row;
        dram_geom_pkg::col_t  col;
        logic                 write;  // 1 for a write request
        dram_geom_pkg::data_t data;   // only meaningful for writes
    } mem_req_t;

endpackage

`default_nettype wire

/* design/bank_queue.sv */
`timescale 1ns/1ns
`default_nettype none

// request FIFO for one bank, oldest entry shown on head
module bank_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   push,
    input  dram_cmd_pkg::mem_req_t push_req,
    input  logic                   pop,
    output dram_cmd_pkg::mem_req_t head,
    output logic                   empty,
    output logic                   full
);
    import dram_cmd_pkg::*;

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    mem_req_t            mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // a full queue takes a push only alongside a pop

    assign empty = (count == '0);
    assign full  = (count == (PTR_BITS + 1)'(QUEUE_DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

endmodule

`default_nettype wire

/* design/bank_state.sv */
`timescale 1ns/1ns
`default_nettype none

// tracks open row and activate/precharge recovery for every bank
module bank_state #(
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic                                                  clk_in,
    input  logic                                                  rst_in,
    input  logic                                                  issue,
    input  dram_cmd_pkg::cmd_t                                    issue_cmd,
    input  dram_geom_pkg::bank_t                                  issue_bank,
    input  dram_geom_pkg::row_t                                   issue_row,
    output logic [dram_geom_pkg::NUM_BANKS-1:0]                   bank_open,
    output logic [dram_geom_pkg::NUM_BANKS-1:0]                   bank_ready,
    output dram_geom_pkg::row_t [dram_geom_pkg::NUM_BANKS-1:0]    open_rows
);
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;

    localparam int MAX_LAT  = (ACT_LATENCY > PRE_LATENCY) ? ACT_LATENCY : PRE_LATENCY;
    localparam int CNT_BITS = $clog2(MAX_LAT + 1);

    logic is_act;
    logic is_pre;

    assign is_act = issue && (issue_cmd == ACTIVATE);
    assign is_pre = issue && (issue_cmd == PRECHARGE);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : banks
        logic                hit;
        logic                open_q;
        row_t                row_q;
        logic [CNT_BITS-1:0] cnt;  // cycles left before the bank takes a command

        assign hit = (issue_bank == bank_t'(b));

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                open_q <= 1'b0;
                cnt    <= '0;
            end else if (hit && is_act) begin
                open_q <= 1'b1;
                cnt    <= CNT_BITS'(ACT_LATENCY);
            end else if (hit && is_pre) begin
                open_q <= 1'b0;
                cnt    <= CNT_BITS'(PRE_LATENCY);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end

        // row is only looked at while open_q is set
        always_ff @(posedge clk_in) begin
            if (hit && is_act) begin
                row_q <= issue_row;
            end
        end

        assign bank_open[b]  = open_q;
        assign bank_ready[b] = (cnt == '0);
        assign open_rows[b]  = row_q;
    end

endmodule

`default_nettype wire

/* design/cmd_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

// round-robin pick over the bank queue heads, one command per cmd_ready cycle
module cmd_arbiter (
    input  logic                                                     clk_in,
    input  logic                                                     rst_in,
    input  logic                                                     cmd_ready,
    input  dram_cmd_pkg::mem_req_t [dram_geom_pkg::NUM_BANKS-1:0]    heads,
    input  logic [dram_geom_pkg::NUM_BANKS-1:0]                      empties,
    input  logic [dram_geom_pkg::NUM_BANKS-1:0]                      bank_open,
    input  logic [dram_geom_pkg::NUM_BANKS-1:0]                      bank_ready,
    input  dram_geom_pkg::row_t [dram_geom_pkg::NUM_BANKS-1:0]       open_rows,
    output logic [dram_geom_pkg::NUM_BANKS-1:0]                      pop,
    output logic                                                     issue,
    output dram_cmd_pkg::cmd_t                                       issue_cmd,
    output dram_geom_pkg::bank_t                                     issue_bank,
    output dram_geom_pkg::row_t                                      issue_row,
    output logic                                                     cmd_valid,
    output dram_cmd_pkg::cmd_t                                       cmd_out,
    output dram_geom_pkg::bank_t                                     cmd_bank,
    output dram_geom_pkg::row_t                                      cmd_row,
    output dram_geom_pkg::col_t                                      cmd_col,
    output dram_geom_pkg::data_t                                     cmd_data
);
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;

    logic [NUM_BANKS-1:0] eligible;
    bank_t                rr_ptr;    // first bank looked at this cycle
    bank_t                grant;
    logic                 found;
    mem_req_t             sel;
    logic                 is_access;

    assign eligible = ~empties & bank_ready;

    // first eligible bank at or after rr_ptr
    always_comb begin
        bank_t idx;
        found = 1'b0;
        grant = rr_ptr;
        for (int i = 0; i < NUM_BANKS; i++) begin
            idx = rr_ptr + bank_t'(i);  // wraps, NUM_BANKS is a power of two
            if (!found && eligible[idx]) begin
                found = 1'b1;
                grant = idx;
            end
        end
    end

    assign sel = heads[grant];

    // what the granted head needs next
    always_comb begin
        if (!bank_open[grant]) begin
            issue_cmd = ACTIVATE;
        end else if (open_rows[grant] != sel.row) begin
            issue_cmd = PRECHARGE;  // row miss, close the old row first
        end else if (sel.write) begin
            issue_cmd = WRITE;
        end else begin
            issue_cmd = READ;
        end
    end

    assign issue      = cmd_ready && found;
    assign issue_bank = grant;
    assign is_access  = (issue_cmd == READ) || (issue_cmd == WRITE);

    // a precharge reports the row it closes
    assign issue_row = (issue_cmd == PRECHARGE) ? open_rows[grant] : sel.row;

    // request leaves its queue only with its read or write
    always_comb begin
        pop = '0;
        if (issue && is_access) begin
            pop[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            cmd_valid <= issue;  // one-cycle strobe
            if (issue) begin
                rr_ptr <= grant + 1'b1;
            end
        end
    end

    // command fields, valid only with cmd_valid
    always_ff @(posedge clk_in) begin
        if (issue) begin
            cmd_out  <= issue_cmd;
            cmd_bank <= grant;
            cmd_row  <= issue_row;
            cmd_col  <= is_access ? sel.col : '0;
            cmd_data <= (issue_cmd == WRITE) ? sel.data : '0;
        end
    end

endmodule

`default_nettype wire

/* design/dram_scheduler.sv */
`timescale 1ns/1ns
`default_nettype none

// command scheduler: one FIFO per bank, bank tracker and round-robin arbiter
module dram_scheduler #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  dram_geom_pkg::addr_t req_addr,
    input  logic                 req_write,
    input  dram_geom_pkg::data_t req_data,
    input  logic                 cmd_ready,
    output logic                 cmd_valid,
    output dram_cmd_pkg::cmd_t   cmd_out,
    output dram_geom_pkg::bank_t cmd_bank,
    output dram_geom_pkg::row_t  cmd_row,
    output dram_geom_pkg::col_t  cmd_col,
    output dram_geom_pkg::data_t cmd_data
);
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;

    logic [BG_BITS-1:0]              req_bg;
    logic [BA_BITS-1:0]              req_ba;
    bank_t                           req_bank;
    row_t                            req_row;
    col_t                            req_col;
    mem_req_t                        push_req;
    logic [NUM_BANKS-1:0]            push;
    logic [NUM_BANKS-1:0]            pop;
    logic [NUM_BANKS-1:0]            empties;
    logic [NUM_BANKS-1:0]            fulls;
    logic [NUM_BANKS-1:0]            bank_open;
    logic [NUM_BANKS-1:0]            bank_ready;
    mem_req_t [NUM_BANKS-1:0]        heads;
    row_t [NUM_BANKS-1:0]            open_rows;
    logic                            issue;
    cmd_t                            issue_cmd;
    bank_t                           issue_bank;
    row_t                            issue_row;

    // address split, msb first: row | bank group | bank | column
    assign req_row  = req_addr[ADDR_BITS-1 -: ROW_BITS];
    assign req_bg   = req_addr[COL_BITS + BA_BITS +: BG_BITS];
    assign req_ba   = req_addr[COL_BITS +: BA_BITS];
    assign req_col  = req_addr[COL_BITS-1:0];
    assign req_bank = {req_bg, req_ba};

    assign push_req = '{row: req_row, col: req_col, write: req_write, data: req_data};

    assign req_ready = !fulls[req_bank];  // only the target queue matters

    always_comb begin
        push = '0;
        push[req_bank] = req_valid && req_ready;
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : bank_queues
        bank_queue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) q0 (
            .clk_in   (clk_in),
            .rst_in   (rst_in),
            .push     (push[b]),
            .push_req (push_req),
            .pop      (pop[b]),
            .head     (heads[b]),
            .empty    (empties[b]),
            .full     (fulls[b])
        );
    end

    bank_state #(
        .ACT_LATENCY(ACT_LATENCY),
        .PRE_LATENCY(PRE_LATENCY)
    ) bank_state0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .issue      (issue),
        .issue_cmd  (issue_cmd),
        .issue_bank (issue_bank),
        .issue_row  (issue_row),
        .bank_open  (bank_open),
        .bank_ready (bank_ready),
        .open_rows  (open_rows)
    );

    cmd_arbiter cmd_arbiter0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cmd_ready  (cmd_ready),
        .heads      (heads),
        .empties    (empties),
        .bank_open  (bank_open),
        .bank_ready (bank_ready),
        .open_rows  (open_rows),
        .pop        (pop),
        .issue      (issue),
        .issue_cmd  (issue_cmd),
        .issue_bank (issue_bank),
        .issue_row  (issue_row),
        .cmd_valid  (cmd_valid),
        .cmd_out    (cmd_out),
        .cmd_bank   (cmd_bank),
        .cmd_row    (cmd_row),
        .cmd_col    (cmd_col),
        .cmd_data   (cmd_data)
    );

endmodule

`default_nettype wire

/* verif/dram_scheduler_properties.sv */
`timescale 1ns/1ns
`default_nettype none

// command stream rules, bound into dram_scheduler
module dram_scheduler_properties #(
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input logic                                clk_in,
    input logic                                rst_in,
    input logic                                cmd_ready,
    input logic                                cmd_valid,
    input dram_cmd_pkg::cmd_t                  cmd_out,
    input dram_geom_pkg::bank_t                cmd_bank,
    input logic [dram_geom_pkg::NUM_BANKS-1:0] push,
    input logic [dram_geom_pkg::NUM_BANKS-1:0] pop,
    input logic [dram_geom_pkg::NUM_BANKS-1:0] fulls
);
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;

    strobe_follows_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        cmd_valid |-> $past(cmd_ready))
        else $error("cmd_valid without cmd_ready in the cycle before");

    quiet_after_reset: assert property (@(posedge clk_in) rst_in |=> !cmd_valid)
        else $error("cmd_valid high right after reset");

    // a full queue may only take a push together with a pop
    no_push_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        (push & fulls & ~pop) == '0)
        else $error("push into a full bank queue");

    for (genvar b = 0; b < NUM_BANKS; b++) begin : per_bank
        act_to_access: assert property (@(posedge clk_in) disable iff (rst_in)
            (cmd_valid && cmd_bank == bank_t'(b) && cmd_out == ACTIVATE) |=>
            (!(cmd_valid && cmd_bank == bank_t'(b) && (cmd_out == READ || cmd_out == WRITE)))
                [*ACT_LATENCY])
            else $error("bank %0d accessed too soon after ACTIVATE", b);

        pre_to_act: assert property (@(posedge clk_in) disable iff (rst_in)
            (cmd_valid && cmd_bank == bank_t'(b) && cmd_out == PRECHARGE) |=>
            (!(cmd_valid && cmd_bank == bank_t'(b) && cmd_out == ACTIVATE)) [*PRE_LATENCY])
            else $error("bank %0d activated too soon after PRECHARGE", b);
    end

endmodule

`default_nettype wire

/* verif/dram_scheduler_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_scheduler_tb;
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;

    localparam string STIM_FILE    = "verif/dram_scheduler_stimulus.txt";
    localparam int    DRAIN_CYCLES = 24;  // quiet time to catch stray commands
    localparam int    QUEUE_DEPTH  = 4;   // dut0 runs with its default depth

    typedef struct packed {
        cmd_t  cmd;
        row_t  row;
        col_t  col;
        data_t data;
    } exp_cmd_t;

    logic        clk_in;
    logic        rst_in;
    logic        req_valid;
    logic        req_ready;
    addr_t       req_addr;
    logic        req_write;
    data_t       req_data;
    logic        cmd_ready;
    logic        cmd_valid;
    cmd_t        cmd_out;
    bank_t       cmd_bank;
    row_t        cmd_row;
    col_t        cmd_col;
    data_t       cmd_data;

    int unsigned req_gaps [$];
    logic        req_writes [$];
    addr_t       req_addrs [$];
    data_t       req_datas [$];
    exp_cmd_t    expected [NUM_BANKS][$];  // per-bank command order from the file
    int unsigned queued [NUM_BANKS];       // requests held in each bank queue
    logic [31:0] lfsr;
    int          cycles = 0;
    int          cycle_limit;

    dram_scheduler dut0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_data  (req_data),
        .cmd_ready (cmd_ready),
        .cmd_valid (cmd_valid),
        .cmd_out   (cmd_out),
        .cmd_bank  (cmd_bank),
        .cmd_row   (cmd_row),
        .cmd_col   (cmd_col),
        .cmd_data  (cmd_data)
    );

    bind dram_scheduler dram_scheduler_properties #(
        .ACT_LATENCY(ACT_LATENCY),
        .PRE_LATENCY(PRE_LATENCY)
    ) props0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cmd_ready (cmd_ready),
        .cmd_valid (cmd_valid),
        .cmd_out   (cmd_out),
        .cmd_bank  (cmd_bank),
        .push      (push),
        .pop       (pop),
        .fulls     (fulls)
    );

    always #4 clk_in = ~clk_in;

    // right-shifting Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // bank group and bank sit just above the column bits
    function automatic bank_t bank_of(input addr_t addr);
        return addr[COL_BITS +: BANK_BITS];
    endfunction

    function automatic bit queues_empty();
        bit done;
        done = 1'b1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (expected[b].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic load_stimulus();
        int          fd;
        string       line;
        logic [31:0] f0, f1, f2, f3, f4;
        exp_cmd_t    e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            stop_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "Q %d %d %h %h", f0, f1, f2, f3) == 4) begin
                    req_gaps.push_back(f0);
                    req_writes.push_back(f1[0]);
                    req_addrs.push_back(addr_t'(f2));
                    req_datas.push_back(f3);
                end else if ($sscanf(line, "E %d %d %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                    e.cmd  = cmd_t'(f1[1:0]);
                    e.row  = row_t'(f2);
                    e.col  = col_t'(f3);
                    e.data = f4;
                    expected[f0[BANK_BITS-1:0]].push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_cmd(input cmd_t got, input cmd_t want, input bank_t bank);
        if (got !== want) begin
            $display("FAIL %0t: bank %0d issued %s, expected %s",
                     $time, bank, got.name(), want.name());
            stop_run();
        end
    endtask

    task automatic compare_fields(input row_t got_row, input col_t got_col,
                                  input data_t got_data, input row_t want_row,
                                  input col_t want_col, input data_t want_data,
                                  input bank_t bank);
        if (got_row !== want_row || got_col !== want_col || got_data !== want_data) begin
            $display("FAIL %0t: bank %0d row/col/data %h/%h/%h, expected %h/%h/%h",
                     $time, bank, got_row, got_col, got_data, want_row, want_col, want_data);
            stop_run();
        end
    endtask

    task automatic compare_ready(input logic got, input logic want, input bank_t bank,
                                 input int unsigned held);
        if (got !== want) begin
            $display("FAIL %0t: req_ready %b for bank %0d holding %0d requests, expected %b",
                     $time, got, bank, held, want);
            stop_run();
        end
    endtask

    task automatic check_command();
        exp_cmd_t want;
        if (expected[cmd_bank].size() == 0) begin
            $display("bank %0d issued a %s command when none was left to issue there",
                     cmd_bank, cmd_out.name());
            stop_run();
        end else begin
            want = expected[cmd_bank].pop_front();
            compare_cmd(cmd_out, want.cmd, cmd_bank);
            compare_fields(cmd_row, cmd_col, cmd_data, want.row, want.col, want.data, cmd_bank);
            if (want.cmd == READ || want.cmd == WRITE) begin
                queued[cmd_bank] -= 1;  // the access took its request off the queue
            end
        end
    endtask

    // controller readiness, one LFSR bit per cycle
    always @(posedge clk_in) begin
        if (rst_in) begin
            cmd_ready <= 1'b0;
        end else begin
            cmd_ready <= lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    end

    // req_ready shows room in the queue of the addressed bank
    always @(posedge clk_in) begin
        if (!rst_in) begin
            compare_ready(req_ready, queued[bank_of(req_addr)] < QUEUE_DEPTH,
                          bank_of(req_addr), queued[bank_of(req_addr)]);
            if (req_valid && req_ready) begin
                queued[bank_of(req_addr)] += 1;
            end
        end
    end

    always @(negedge clk_in) begin
        if (!rst_in && cmd_valid) begin
            check_command();
        end
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with commands still outstanding", cycles);
            stop_run();
        end
    end

    initial begin
        clk_in    = 1'b0;
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_data  = '0;
        cmd_ready = 1'b0;
        lfsr      = 32'h9c2f;
        load_stimulus();
        cycle_limit = 200 + 64 * req_addrs.size();
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;
        for (int i = 0; i < req_addrs.size(); i++) begin
            if (req_gaps[i] > 0) begin
                req_valid <= 1'b0;
                repeat (req_gaps[i]) @(posedge clk_in);
            end
            req_valid <= 1'b1;
            req_addr  <= req_addrs[i];
            req_write <= req_writes[i];
            req_data  <= req_datas[i];
            do begin
                @(posedge clk_in);
            end while (!req_ready);  // held under back-pressure
        end
        req_valid <= 1'b0;
        while (!queues_empty()) begin
            @(negedge clk_in);
        end
        repeat (DRAIN_CYCLES) @(negedge clk_in);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* dram_scheduler.f */
design/dram_geom_pkg.sv
design/dram_cmd_pkg.sv
design/bank_queue.sv
design/bank_state.sv
design/cmd_arbiter.sv
design/dram_scheduler.sv
verif/dram_scheduler_properties.sv
verif/dram_scheduler_tb.sv

/* verif/dram_scheduler_stimulus.txt */
# Q idle_gap write addr(hex: row[14:7] bg[6] bank[5:4] col[3:0]) data(hex)
# E bank cmd(0 READ 1 WRITE 2 ACTIVATE 3 PRECHARGE) row col data, all but bank/cmd in hex
Q 0 0 0803 00000000
Q 2 1 19D7 A5A50001
Q 1 1 0805 12345678
Q 0 0 19D2 00000000
Q 3 0 1101 00000000
Q 0 1 3FEF DEADBEEF
Q 0 0 00D0 00000000
Q 4 1 2030 00000030
Q 0 1 2031 00000031
Q 0 1 2032 00000032
Q 0 1 2033 00000033
Q 0 1 2034 00000034
Q 0 0 7FF9 00000000
Q 0 0 110E 00000000
E 0 2 10 0 00000000
E 0 0 10 3 00000000
E 0 1 10 5 12345678
E 0 3 10 0 00000000
E 0 2 22 0 00000000
E 0 0 22 1 00000000
E 0 0 22 e 00000000
E 5 2 33 0 00000000
E 5 1 33 7 A5A50001
E 5 0 33 2 00000000
E 5 3 33 0 00000000
E 5 2 01 0 00000000
E 5 0 01 0 00000000
E 6 2 7f 0 00000000
E 6 1 7f f DEADBEEF
E 3 2 40 0 00000000
E 3 1 40 0 00000030
E 3 1 40 1 00000031
E 3 1 40 2 00000032
E 3 1 40 3 00000033
E 3 1 40 4 00000034
E 7 2 ff 0 00000000
E 7 0 ff 9 00000000
